// File: vlog.f
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex1_stage.sv
verilog/ex1_ex2_reg.sv
verilog/ex2_stage.sv
verilog/ex_csr.sv
verilog/ex_top.sv
verification/ex_tb_assert.sv
verification/ex_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module ex_tb -f vlog.f

run: compile
	@out="$$(./obj_dir/Vex_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir

// File: verification/ex_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_cfg.svh"

module ex_tb import ex_pkg::*; ();

    localparam int N_ALU = 40;
    localparam int N_MUL = 30;
    localparam int N_BP = 60;
    localparam int N_LANE = 16;
    localparam int N_PAIRS = N_ALU + N_MUL + N_BP + 1 + 2 * N_LANE;
    localparam int TIMEOUT_CYCLES = 40 * N_PAIRS + 500;

    typedef struct packed {
        data_t  r0;
        data_t  r1;
        reg_idx rd0;
        reg_idx rd1;
        logic   v0;
        logic   v1;
    } exp_t;

    logic clk;
    logic arst_n;
    logic flush;
    logic forward_stall;
    logic in_valid;
    logic in_ready;
    logic out_valid;
    logic out_ready;
    uop_t uop0, uop1;
    data_t src_a0, src_b0, src_a1, src_b1;
    reg_idx rd0, rd1;
    data_t res0, res1;
    reg_idx res_rd0, res_rd1;
    logic res_valid0, res_valid1;
    logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
    logic [`EX_CSR_AW-1:0] s_axi_awaddr, s_axi_araddr;
    data_t s_axi_wdata, s_axi_rdata;
    logic [`EX_DATA_W/8-1:0] s_axi_wstrb;
    logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
    logic s_axi_rvalid, s_axi_rready;
    logic [1:0] s_axi_bresp, s_axi_rresp;

    logic [31:0] lfsr;
    exp_t exp_q[$];
    logic lane1_model;
    logic bp_mode;
    logic loaded;
    cnt_t retired_model;
    int cycles;
    int n_data_err, n_idx_err, n_flag_err, n_cnt_err, n_resp_err, n_other_err;

    ex_top u_dut (.*);

    always #50 clk = ~clk;

    // ==============================
    // stimulus and reference
    // ==============================

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit.
    function automatic data_t draw(input int n);
        data_t v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic uop_t rand_uop(input int kind);
        uop_t u;
        case (kind)
            0:       u = uop_t'(draw(3) % 6);
            1:       u = draw(1) ? uop_mulhu : uop_mul;
            default: u = uop_t'(draw(3));
        endcase
        return u;
    endfunction

    function automatic data_t ref_result(input uop_t uop, input data_t a, input data_t b);
        prod_t p;
        data_t r;
        p = prod_t'(a) * prod_t'(b);
        case (uop)
            uop_add:  r = a + b;
            uop_sub:  r = a - b;
            uop_and:  r = a & b;
            uop_or:   r = a | b;
            uop_xor:  r = a ^ b;
            uop_sltu: r = (a < b) ? 32'd1 : 32'd0;
            uop_mul:  r = p[31:0];
            default:  r = p[63:32];
        endcase
        return r;
    endfunction

    function automatic exp_t build_expect();
        exp_t e;
        e.r0 = ref_result(uop0, src_a0, src_b0);
        e.r1 = ref_result(uop1, src_a1, src_b1);
        e.rd0 = rd0;
        e.rd1 = rd1;
        e.v0 = 1'b1;
        e.v1 = lane1_model;
        return e;
    endfunction

    // ==============================
    // checks
    // ==============================

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s got %h, expected %h", $time, what, got, exp);
            n_data_err++;
        end
    endtask

    task automatic check_idx(input reg_idx got, input reg_idx exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s got %0d, expected %0d", $time, what, got, exp);
            n_idx_err++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s got %b, expected %b", $time, what, got, exp);
            n_flag_err++;
        end
    endtask

    task automatic check_cnt(input cnt_t got, input cnt_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s got %0d, expected %0d", $time, what, got, exp);
            n_cnt_err++;
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s got %b, expected %b", $time, what, got, exp);
            n_resp_err++;
        end
    endtask

    task automatic compare_result(input exp_t e);
        check_flag(res_valid0, e.v0, "res_valid0");
        check_flag(res_valid1, e.v1, "res_valid1");
        if (e.v0) begin
            check_data(res0, e.r0, "res0");
            check_idx(res_rd0, e.rd0, "res_rd0");
        end
        if (e.v1) begin
            check_data(res1, e.r1, "res1");
            check_idx(res_rd1, e.rd1, "res_rd1");
        end
        retired_model += cnt_t'(e.v0) + cnt_t'(e.v1);
    endtask

    // pops before it pushes, so an entry never meets itself.
    always @(posedge clk) begin
        exp_t e;
        if (arst_n) begin
            // a pair taken at the previous edge is presented right after it.
            if (loaded) begin
                check_flag(out_valid, 1'b1, "out_valid one cycle after issue");
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output transfer at %0t with no result pending", $time);
                    n_other_err++;
                end else begin
                    e = exp_q.pop_front();
                    compare_result(e);
                end
            end else if (flush && out_valid && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            loaded = in_valid && in_ready && !flush;
            if (loaded) begin
                exp_q.push_back(build_expect());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ==============================
    // bus tasks
    // ==============================

    task automatic set_knobs();
        if (bp_mode) begin
            out_ready = (draw(2) != 0);
            forward_stall = (draw(3) == 0);
        end
    endtask

    task automatic issue_pair(input int kind);
        @(negedge clk);
        set_knobs();
        in_valid = 1'b1;
        uop0 = rand_uop(kind);
        uop1 = rand_uop(kind);
        src_a0 = draw(32);
        src_b0 = draw(32);
        src_a1 = draw(32);
        src_b1 = draw(32);
        rd0 = reg_idx'(draw(5));
        rd1 = reg_idx'(draw(5));
        @(posedge clk);
        while (!in_ready) begin
            @(negedge clk);
            set_knobs();
            @(posedge clk);
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        set_knobs();
        in_valid = 1'b0;
    endtask

    task automatic drain();
        @(negedge clk);
        in_valid = 1'b0;
        out_ready = 1'b1;
        forward_stall = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic axi_write(input logic [`EX_CSR_AW-1:0] addr, input data_t data);
        @(negedge clk);
        s_axi_awvalid = 1'b1;
        s_axi_awaddr = addr;
        s_axi_wvalid = 1'b1;
        s_axi_wdata = data;
        s_axi_wstrb = '1;
        @(posedge clk);
        while (!(s_axi_awready && s_axi_wready)) @(posedge clk);
        @(negedge clk);
        s_axi_awvalid = 1'b0;
        s_axi_wvalid = 1'b0;
        s_axi_bready = 1'b1;
        @(posedge clk);
        while (!s_axi_bvalid) @(posedge clk);
        check_resp(s_axi_bresp, 2'b00, "bresp");
        @(negedge clk);
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [`EX_CSR_AW-1:0] addr, output data_t data);
        @(negedge clk);
        s_axi_arvalid = 1'b1;
        s_axi_araddr = addr;
        @(posedge clk);
        while (!s_axi_arready) @(posedge clk);
        @(negedge clk);
        s_axi_arvalid = 1'b0;
        s_axi_rready = 1'b1;
        @(posedge clk);
        while (!s_axi_rvalid) @(posedge clk);
        data = s_axi_rdata;
        check_resp(s_axi_rresp, 2'b00, "rresp");
        @(negedge clk);
        s_axi_rready = 1'b0;
    endtask

    // ==============================
    // test sequence
    // ==============================

    initial begin
        data_t rd_val;
        int total;
        clk = 1'b0;
        arst_n = 1'b0;
        flush = 1'b0;
        forward_stall = 1'b0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        uop0 = uop_add;
        uop1 = uop_add;
        src_a0 = '0;
        src_b0 = '0;
        src_a1 = '0;
        src_b1 = '0;
        rd0 = '0;
        rd1 = '0;
        s_axi_awvalid = 1'b0;
        s_axi_awaddr = '0;
        s_axi_wvalid = 1'b0;
        s_axi_wdata = '0;
        s_axi_wstrb = '0;
        s_axi_bready = 1'b0;
        s_axi_arvalid = 1'b0;
        s_axi_araddr = '0;
        s_axi_rready = 1'b0;
        lfsr = 32'd95386;
        lane1_model = 1'b1;
        bp_mode = 1'b0;
        loaded = 1'b0;
        retired_model = '0;
        cycles = 0;
        n_data_err = 0;
        n_idx_err = 0;
        n_flag_err = 0;
        n_cnt_err = 0;
        n_resp_err = 0;
        n_other_err = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < N_ALU; i++) issue_pair(0);
        drain();
        for (int i = 0; i < N_MUL; i++) issue_pair(1);
        drain();

        axi_read(`EX_CSR_RETIRED, rd_val);
        check_cnt(cnt_t'(rd_val), retired_model, "RETIRED");
        axi_write(`EX_CSR_RETIRED, 32'h1);
        retired_model = '0;
        axi_read(`EX_CSR_RETIRED, rd_val);
        check_cnt(cnt_t'(rd_val), retired_model, "RETIRED after clear");
        axi_read(4'h8, rd_val);
        check_data(rd_val, '0, "unmapped read");

        // random back-pressure, stall pulses and bubbles.
        bp_mode = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            issue_pair(2);
            if (draw(2) == 0) idle_cycle();
        end
        bp_mode = 1'b0;
        drain();

        // one pair left pending, then flushed.
        @(negedge clk);
        out_ready = 1'b0;
        issue_pair(2);
        @(negedge clk);
        in_valid = 1'b0;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_flag(out_valid, 1'b0, "out_valid after flush");
        if (exp_q.size() != 0) begin
            $display("flushed result is still expected at the output");
            n_other_err++;
        end
        out_ready = 1'b1;
        repeat (2) @(negedge clk);

        axi_write(`EX_CSR_CTRL, 32'h0);
        lane1_model = 1'b0;
        repeat (2) @(negedge clk);
        for (int i = 0; i < N_LANE; i++) issue_pair(2);
        drain();
        axi_read(`EX_CSR_CTRL, rd_val);
        check_data(rd_val, 32'h0, "CTRL");
        axi_write(`EX_CSR_CTRL, 32'h1);
        lane1_model = 1'b1;
        repeat (2) @(negedge clk);
        for (int i = 0; i < N_LANE; i++) issue_pair(2);
        drain();

        axi_read(`EX_CSR_RETIRED, rd_val);
        check_cnt(cnt_t'(rd_val), retired_model, "RETIRED");
        if (exp_q.size() != 0) begin
            $display("%0d results were still pending at the end", exp_q.size());
            n_other_err++;
        end

        total = n_data_err + n_idx_err + n_flag_err + n_cnt_err + n_resp_err + n_other_err;
        $display("errors: data %0d, index %0d, flag %0d, counter %0d, response %0d, other %0d",
                 n_data_err, n_idx_err, n_flag_err, n_cnt_err, n_resp_err, n_other_err);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/ex_tb_assert.sv
`timescale 1ns/100ps
`default_nettype none

module ex_tb_assert import ex_pkg::*; (
    input logic   clk,
    input logic   arst_n,
    input logic   flush,
    input logic   out_valid,
    input logic   out_ready,
    input uop_t   uop0_r,
    input uop_t   uop1_r,
    input reg_idx rd0_r,
    input reg_idx rd1_r,
    input data_t  alu_res0_r,
    input data_t  alu_res1_r,
    input logic   alu_valid0_r,
    input logic   alu_valid1_r,
    input data_t  mul_ll0_r,
    input data_t  mul_ll1_r
);

    // register is empty while reset is applied.
    a_reset_empty: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high during reset");

    // a presented result holds until it is taken.
    a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready && !flush |=> out_valid && $stable({uop0_r, uop1_r,
            rd0_r, rd1_r, alu_res0_r, alu_res1_r, alu_valid0_r, alu_valid1_r,
            mul_ll0_r, mul_ll1_r}))
        else $error("pipeline register changed under back-pressure");

    a_flush_empty: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !out_valid)
        else $error("out_valid high after flush");

endmodule

bind ex1_ex2_reg ex_tb_assert u_assert (
    .clk(clk), .arst_n(arst_n), .flush(flush),
    .out_valid(out_valid), .out_ready(out_ready),
    .uop0_r(uop0_r), .uop1_r(uop1_r), .rd0_r(rd0_r), .rd1_r(rd1_r),
    .alu_res0_r(alu_res0_r), .alu_res1_r(alu_res1_r),
    .alu_valid0_r(alu_valid0_r), .alu_valid1_r(alu_valid1_r),
    .mul_ll0_r(mul_ll0_r), .mul_ll1_r(mul_ll1_r)
);

`default_nettype wire

// File: verilog/ex_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_cfg.svh"

module ex_top import ex_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    flush,
    input  logic                    forward_stall,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  uop_t                    uop0,
    input  uop_t                    uop1,
    input  data_t                   src_a0,
    input  data_t                   src_b0,
    input  data_t                   src_a1,
    input  data_t                   src_b1,
    input  reg_idx                  rd0,
    input  reg_idx                  rd1,
    output logic                    out_valid,
    input  logic                    out_ready,
    output data_t                   res0,
    output data_t                   res1,
    output reg_idx                  res_rd0,
    output reg_idx                  res_rd1,
    output logic                    res_valid0,
    output logic                    res_valid1,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    input  logic [`EX_CSR_AW-1:0]   s_axi_awaddr,
    input  logic                    s_axi_wvalid,
    output logic                    s_axi_wready,
    input  data_t                   s_axi_wdata,
    input  logic [`EX_DATA_W/8-1:0] s_axi_wstrb,
    output logic                    s_axi_bvalid,
    input  logic                    s_axi_bready,
    output logic [1:0]              s_axi_bresp,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    input  logic [`EX_CSR_AW-1:0]   s_axi_araddr,
    output logic                    s_axi_rvalid,
    input  logic                    s_axi_rready,
    output data_t                   s_axi_rdata,
    output logic [1:0]              s_axi_rresp
);

    // ex1 outputs.
    data_t      alu_res0, alu_res1;
    logic       alu_valid0, alu_valid1, lane1_act;
    data_t      mul_hh0, mul_hl0, mul_lh0, mul_ll0;
    data_t      mul_hh1, mul_hl1, mul_lh1, mul_ll1;

    // pipeline register outputs.
    uop_t       uop0_r, uop1_r;
    reg_idx     rd0_r, rd1_r;
    data_t      alu_res0_r, alu_res1_r;
    logic       alu_valid0_r, alu_valid1_r, lane1_act_r;
    data_t      mul_hh0_r, mul_hl0_r, mul_lh0_r, mul_ll0_r;
    data_t      mul_hh1_r, mul_hl1_r, mul_lh1_r, mul_ll1_r;

    logic       lane1_en;
    logic [1:0] retire_cnt;

    ex1_stage u_ex1 (
        .clk(clk), .arst_n(arst_n),
        .uop0(uop0), .uop1(uop1),
        .src_a0(src_a0), .src_b0(src_b0), .src_a1(src_a1), .src_b1(src_b1),
        .lane1_en(lane1_en),
        .alu_res0(alu_res0), .alu_res1(alu_res1),
        .alu_valid0(alu_valid0), .alu_valid1(alu_valid1), .lane1_act(lane1_act),
        .mul_hh0(mul_hh0), .mul_hl0(mul_hl0), .mul_lh0(mul_lh0), .mul_ll0(mul_ll0),
        .mul_hh1(mul_hh1), .mul_hl1(mul_hl1), .mul_lh1(mul_lh1), .mul_ll1(mul_ll1)
    );

    ex1_ex2_reg u_pipe (
        .clk(clk), .arst_n(arst_n), .flush(flush), .forward_stall(forward_stall),
        .in_valid(in_valid), .out_ready(out_ready),
        .in_ready(in_ready), .out_valid(out_valid),
        .uop0(uop0), .uop1(uop1), .rd0(rd0), .rd1(rd1),
        .alu_res0(alu_res0), .alu_res1(alu_res1),
        .alu_valid0(alu_valid0), .alu_valid1(alu_valid1), .lane1_act(lane1_act),
        .mul_hh0(mul_hh0), .mul_hl0(mul_hl0), .mul_lh0(mul_lh0), .mul_ll0(mul_ll0),
        .mul_hh1(mul_hh1), .mul_hl1(mul_hl1), .mul_lh1(mul_lh1), .mul_ll1(mul_ll1),
        .uop0_r(uop0_r), .uop1_r(uop1_r), .rd0_r(rd0_r), .rd1_r(rd1_r),
        .alu_res0_r(alu_res0_r), .alu_res1_r(alu_res1_r),
        .alu_valid0_r(alu_valid0_r), .alu_valid1_r(alu_valid1_r),
        .lane1_act_r(lane1_act_r),
        .mul_hh0_r(mul_hh0_r), .mul_hl0_r(mul_hl0_r),
        .mul_lh0_r(mul_lh0_r), .mul_ll0_r(mul_ll0_r),
        .mul_hh1_r(mul_hh1_r), .mul_hl1_r(mul_hl1_r),
        .mul_lh1_r(mul_lh1_r), .mul_ll1_r(mul_ll1_r)
    );

    ex2_stage u_ex2 (
        .pipe_valid(out_valid), .out_ready(out_ready),
        .uop0(uop0_r), .uop1(uop1_r), .rd0(rd0_r), .rd1(rd1_r),
        .alu_res0(alu_res0_r), .alu_res1(alu_res1_r),
        .alu_valid0(alu_valid0_r), .alu_valid1(alu_valid1_r), .lane1_act(lane1_act_r),
        .mul_hh0(mul_hh0_r), .mul_hl0(mul_hl0_r), .mul_lh0(mul_lh0_r), .mul_ll0(mul_ll0_r),
        .mul_hh1(mul_hh1_r), .mul_hl1(mul_hl1_r), .mul_lh1(mul_lh1_r), .mul_ll1(mul_ll1_r),
        .res0(res0), .res1(res1), .res_rd0(res_rd0), .res_rd1(res_rd1),
        .res_valid0(res_valid0), .res_valid1(res_valid1),
        .retire_cnt(retire_cnt)
    );

    ex_csr u_csr (
        .clk(clk), .arst_n(arst_n),
        .s_axi_awvalid(s_axi_awvalid), .s_axi_awready(s_axi_awready),
        .s_axi_awaddr(s_axi_awaddr),
        .s_axi_wvalid(s_axi_wvalid), .s_axi_wready(s_axi_wready),
        .s_axi_wdata(s_axi_wdata), .s_axi_wstrb(s_axi_wstrb),
        .s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
        .s_axi_bresp(s_axi_bresp),
        .s_axi_arvalid(s_axi_arvalid), .s_axi_arready(s_axi_arready),
        .s_axi_araddr(s_axi_araddr),
        .s_axi_rvalid(s_axi_rvalid), .s_axi_rready(s_axi_rready),
        .s_axi_rdata(s_axi_rdata), .s_axi_rresp(s_axi_rresp),
        .retire_cnt(retire_cnt), .lane1_en(lane1_en)
    );

endmodule

`default_nettype wire

// File: verilog/ex_csr.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_cfg.svh"

module ex_csr import ex_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   s_axi_awvalid,
    output logic                   s_axi_awready,
    input  logic [`EX_CSR_AW-1:0]  s_axi_awaddr,
    input  logic                   s_axi_wvalid,
    output logic                   s_axi_wready,
    input  data_t                  s_axi_wdata,
    input  logic [`EX_DATA_W/8-1:0] s_axi_wstrb,
    output logic                   s_axi_bvalid,
    input  logic                   s_axi_bready,
    output logic [1:0]             s_axi_bresp,
    input  logic                   s_axi_arvalid,
    output logic                   s_axi_arready,
    input  logic [`EX_CSR_AW-1:0]  s_axi_araddr,
    output logic                   s_axi_rvalid,
    input  logic                   s_axi_rready,
    output data_t                  s_axi_rdata,
    output logic [1:0]             s_axi_rresp,
    input  logic [1:0]             retire_cnt,
    output logic                   lane1_en
);

    csr_wstate_e wstate;
    cnt_t        retired;
    logic        wr_fire;
    logic        rd_fire;

    // ==============================
    // write channel
    // ==============================

    // address and data are taken in the same cycle.
    assign wr_fire       = (wstate == wr_idle) && s_axi_awvalid && s_axi_wvalid;
    assign s_axi_awready = wr_fire;
    assign s_axi_wready  = wr_fire;
    assign s_axi_bvalid  = (wstate == wr_resp);
    assign s_axi_bresp   = 2'b00;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wstate <= wr_idle;
        end else begin
            case (wstate)
                wr_idle: if (wr_fire) wstate <= wr_resp;
                wr_resp: if (s_axi_bready) wstate <= wr_idle;
            endcase
        end
    end

    // ==============================
    // registers
    // ==============================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane1_en <= 1'b1;
            retired  <= '0;
        end else begin
            if (wr_fire && s_axi_awaddr == `EX_CSR_CTRL && s_axi_wstrb[0]) begin
                lane1_en <= s_axi_wdata[0];
            end
            // a clear wins over a retirement in the same cycle.
            if (wr_fire && s_axi_awaddr == `EX_CSR_RETIRED) begin
                retired <= '0;
            end else begin
                retired <= retired + cnt_t'(retire_cnt);
            end
        end
    end

    // ==============================
    // read channel
    // ==============================

    assign s_axi_arready = ~s_axi_rvalid;
    assign rd_fire       = s_axi_arvalid && s_axi_arready;
    assign s_axi_rresp   = 2'b00;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s_axi_rvalid <= 1'b0;
        end else if (rd_fire) begin
            s_axi_rvalid <= 1'b1;
        end else if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
        end
    end

    // read data is sampled at the address handshake.
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            case (s_axi_araddr)
                `EX_CSR_CTRL:    s_axi_rdata <= data_t'(lane1_en);
                `EX_CSR_RETIRED: s_axi_rdata <= retired;
                default:         s_axi_rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/ex2_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex2_stage import ex_pkg::*; (
    input  logic       pipe_valid,
    input  logic       out_ready,
    input  uop_t       uop0,
    input  uop_t       uop1,
    input  reg_idx     rd0,
    input  reg_idx     rd1,
    input  data_t      alu_res0,
    input  data_t      alu_res1,
    input  logic       alu_valid0,
    input  logic       alu_valid1,
    input  logic       lane1_act,
    input  data_t      mul_hh0,
    input  data_t      mul_hl0,
    input  data_t      mul_lh0,
    input  data_t      mul_ll0,
    input  data_t      mul_hh1,
    input  data_t      mul_hl1,
    input  data_t      mul_lh1,
    input  data_t      mul_ll1,
    output data_t      res0,
    output data_t      res1,
    output reg_idx     res_rd0,
    output reg_idx     res_rd1,
    output logic       res_valid0,
    output logic       res_valid1,
    output logic [1:0] retire_cnt
);

    prod_t prod0;
    prod_t prod1;

    // hh and ll do not overlap, so they concatenate; the cross terms sit one half up.
    function automatic prod_t mul_combine(input data_t hh, input data_t hl,
                                          input data_t lh, input data_t ll);
        return {hh, ll} + (prod_t'(hl) << $bits(half_t)) + (prod_t'(lh) << $bits(half_t));
    endfunction

    function automatic data_t lane_sel(input uop_t uop, input data_t alu, input prod_t prod);
        data_t r;
        case (uop)
            uop_mul:   r = data_t'(prod);
            uop_mulhu: r = data_t'(prod >> $bits(data_t));
            default:   r = alu;
        endcase
        return r;
    endfunction

    assign prod0 = mul_combine(mul_hh0, mul_hl0, mul_lh0, mul_ll0);
    assign prod1 = mul_combine(mul_hh1, mul_hl1, mul_lh1, mul_ll1);

    assign res0    = lane_sel(uop0, alu_res0, prod0);
    assign res1    = lane_sel(uop1, alu_res1, prod1);
    assign res_rd0 = rd0;
    assign res_rd1 = rd1;

    // lane 0 is always active.
    assign res_valid0 = pipe_valid & (alu_valid0 | is_mul_uop(uop0));
    assign res_valid1 = pipe_valid & (alu_valid1 | (is_mul_uop(uop1) & lane1_act));

    assign retire_cnt = (pipe_valid && out_ready) ? 2'(res_valid0) + 2'(res_valid1) : 2'd0;

endmodule

`default_nettype wire

// File: verilog/ex1_ex2_reg.sv
`timescale 1ns/100ps
`default_nettype none

module ex1_ex2_reg import ex_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   flush,
    input  logic   forward_stall,
    input  logic   in_valid,
    input  logic   out_ready,
    output logic   in_ready,
    output logic   out_valid,
    input  uop_t   uop0,
    input  uop_t   uop1,
    input  reg_idx rd0,
    input  reg_idx rd1,
    input  data_t  alu_res0,
    input  data_t  alu_res1,
    input  logic   alu_valid0,
    input  logic   alu_valid1,
    input  logic   lane1_act,
    input  data_t  mul_hh0,
    input  data_t  mul_hl0,
    input  data_t  mul_lh0,
    input  data_t  mul_ll0,
    input  data_t  mul_hh1,
    input  data_t  mul_hl1,
    input  data_t  mul_lh1,
    input  data_t  mul_ll1,
    output uop_t   uop0_r,
    output uop_t   uop1_r,
    output reg_idx rd0_r,
    output reg_idx rd1_r,
    output data_t  alu_res0_r,
    output data_t  alu_res1_r,
    output logic   alu_valid0_r,
    output logic   alu_valid1_r,
    output logic   lane1_act_r,
    output data_t  mul_hh0_r,
    output data_t  mul_hl0_r,
    output data_t  mul_lh0_r,
    output data_t  mul_ll0_r,
    output data_t  mul_hh1_r,
    output data_t  mul_hl1_r,
    output data_t  mul_lh1_r,
    output data_t  mul_ll1_r
);

    logic xfer;

    // accept when empty or draining, unless a forwarding stall holds the issue.
    assign in_ready = ~forward_stall & (~out_valid | out_ready);
    assign xfer     = in_valid & in_ready;

    // ==============================
    // valid bits
    // ==============================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid    <= 1'b0;
            alu_valid0_r <= 1'b0;
            alu_valid1_r <= 1'b0;
            lane1_act_r  <= 1'b0;
        end else if (xfer && !flush) begin
            out_valid    <= 1'b1;
            alu_valid0_r <= alu_valid0;
            alu_valid1_r <= alu_valid1;
            lane1_act_r  <= lane1_act;
        end else if (flush || out_ready) begin
            // flush, or a drain with nothing behind it loads a bubble.
            out_valid    <= 1'b0;
            alu_valid0_r <= 1'b0;
            alu_valid1_r <= 1'b0;
            lane1_act_r  <= 1'b0;
        end
    end

    // ==============================
    // payload
    // ==============================

    always_ff @(posedge clk) begin
        if (xfer) begin
            uop0_r     <= uop0;
            uop1_r     <= uop1;
            rd0_r      <= rd0;
            rd1_r      <= rd1;
            alu_res0_r <= alu_res0;
            alu_res1_r <= alu_res1;
            mul_hh0_r  <= mul_hh0;
            mul_hl0_r  <= mul_hl0;
            mul_lh0_r  <= mul_lh0;
            mul_ll0_r  <= mul_ll0;
            mul_hh1_r  <= mul_hh1;
            mul_hl1_r  <= mul_hl1;
            mul_lh1_r  <= mul_lh1;
            mul_ll1_r  <= mul_ll1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ex1_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex1_stage import ex_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  uop_t  uop0,
    input  uop_t  uop1,
    input  data_t src_a0,
    input  data_t src_b0,
    input  data_t src_a1,
    input  data_t src_b1,
    input  logic  lane1_en,
    output data_t alu_res0,
    output data_t alu_res1,
    output logic  alu_valid0,
    output logic  alu_valid1,
    output logic  lane1_act,
    output data_t mul_hh0,
    output data_t mul_hl0,
    output data_t mul_lh0,
    output data_t mul_ll0,
    output data_t mul_hh1,
    output data_t mul_hl1,
    output data_t mul_lh1,
    output data_t mul_ll1
);

    logic  lane1_en_q;
    half_t a0_hi, a0_lo, b0_hi, b0_lo;
    half_t a1_hi, a1_lo, b1_hi, b1_lo;

    function automatic data_t alu_op(input uop_t uop, input data_t a, input data_t b);
        data_t r;
        case (uop)
            uop_add:  r = a + b;
            uop_sub:  r = a - b;
            uop_and:  r = a & b;
            uop_or:   r = a | b;
            uop_xor:  r = a ^ b;
            uop_sltu: r = data_t'(a < b);
            default:  r = '0;
        endcase
        return r;
    endfunction

    function automatic data_t mul_pp(input half_t x, input half_t y);
        return data_t'(x) * data_t'(y);
    endfunction

    // lane 1 enable changes only at a clock edge, so a pair never sees it change mid-issue.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane1_en_q <= 1'b1;
        end else begin
            lane1_en_q <= lane1_en;
        end
    end

    assign lane1_act = lane1_en_q;

    // ==============================
    // alu
    // ==============================

    assign alu_res0   = alu_op(uop0, src_a0, src_b0);
    assign alu_res1   = alu_op(uop1, src_a1, src_b1);
    assign alu_valid0 = ~is_mul_uop(uop0);
    assign alu_valid1 = ~is_mul_uop(uop1) & lane1_en_q;

    // ==============================
    // multiplier partial products
    // ==============================

    assign {a0_hi, a0_lo} = src_a0;
    assign {b0_hi, b0_lo} = src_b0;
    assign {a1_hi, a1_lo} = src_a1;
    assign {b1_hi, b1_lo} = src_b1;

    assign mul_hh0 = mul_pp(a0_hi, b0_hi);
    assign mul_hl0 = mul_pp(a0_hi, b0_lo);
    assign mul_lh0 = mul_pp(a0_lo, b0_hi);
    assign mul_ll0 = mul_pp(a0_lo, b0_lo);
    assign mul_hh1 = mul_pp(a1_hi, b1_hi);
    assign mul_hl1 = mul_pp(a1_hi, b1_lo);
    assign mul_lh1 = mul_pp(a1_lo, b1_hi);
    assign mul_ll1 = mul_pp(a1_lo, b1_lo);

endmodule

`default_nettype wire

// File: verilog/ex_pkg.sv
`default_nettype none

`include "ex_cfg.svh"

package ex_pkg;

    typedef logic [`EX_DATA_W-1:0] data_t;
    typedef logic [`EX_DATA_W/2-1:0] half_t;
    typedef logic [2*`EX_DATA_W-1:0] prod_t;
    typedef logic [`EX_UOP_W-1:0] uop_t;
    typedef logic [4:0] reg_idx;
    typedef logic [31:0] cnt_t;

    // operation codes.
    localparam uop_t uop_add = 3'd0;
    localparam uop_t uop_sub = 3'd1;
    localparam uop_t uop_and = 3'd2;
    localparam uop_t uop_or = 3'd3;
    localparam uop_t uop_xor = 3'd4;
    localparam uop_t uop_sltu = 3'd5;
    localparam uop_t uop_mul = 3'd6;
    localparam uop_t uop_mulhu = 3'd7;

    typedef enum logic {
        wr_idle,
        wr_resp
    } csr_wstate_e;

    function automatic logic is_mul_uop(input uop_t uop);
        return (uop == uop_mul) || (uop == uop_mulhu);
    endfunction

endpackage

`default_nettype wire

// File: verilog/ex_cfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// datapath widths.
`define EX_DATA_W 32
`define EX_UOP_W 3

// register block address map, sized to EX_CSR_AW.
`define EX_CSR_AW 4
`define EX_CSR_CTRL 4'h0
`define EX_CSR_RETIRED 4'h4

`endif
